//--- hdl/addrWalker.sv
// Address walker: steps through the RTC map, times the access strobe, applies skip rules
`timescale 1ns/1ps

module addrWalker
#(
	parameter int accessLimit = 8
)
(
	input  logic              CLK,
	input  logic              RST,
	input  logic              frw,        // End of one RTC transfer
	input  logic              alarmStop,
	input  logic              irq,        // Low while an RTC event is pending
	btnIf.timerSink           btn,
	scanIf.slave              scan,
	output logic              access,
	output rtcMapPkg::rtcAddrT addr
);
	import rtcMapPkg::*;
	import menuCtrlPkg::*;

	localparam int cntW = $clog2(accessLimit + 1);

	walkStateT       state;
	walkStateT       stateNext;
	rtcAddrT         addrNext;
	logic            accessNext;
	logic [cntW-1:0] accessCnt;      // Cycles access has been high
	logic            accessExpired;  // Last allowed high cycle
	logic            bootSeen;       // First init transfer done
	logic            bootSeenNext;
	logic            alarmWanted;    // Alarm registers must be served
	logic            scanDone;
	logic            timerConsume;

	////////////////////////////////////////////////////////////
	// Access timer
	////////////////////////////////////////////////////////////
	assign accessExpired = access && (accessCnt == cntW'(accessLimit - 1));

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			accessCnt <= '0;
		else if (access)
			accessCnt <= accessCnt + 1'b1;
		else
			accessCnt <= '0;
	end

	assign alarmWanted = btn.timerReq | alarmStop;

	////////////////////////////////////////////////////////////
	// Walk
	////////////////////////////////////////////////////////////
	always_comb
	begin
		stateNext    = state;
		addrNext     = addr;
		accessNext   = access;
		bootSeenNext = bootSeen;
		scanDone     = 1'b0;
		timerConsume = 1'b0;
		case (state)
			walkBoot:
				if (frw)
				begin
					accessNext = 1'b0;
					if (bootSeen)
						stateNext = walkIdle;  // Second init transfer done
					else
						bootSeenNext = 1'b1;
				end
				else if (!access)
					accessNext = 1'b1;  // Next init transfer
			walkIdle:
				if (scan.scanReq)
				begin
					addrNext   = scanStart;
					accessNext = 1'b1;
					stateNext  = walkTransfer;
				end
			walkTransfer:
				if (frw)
				begin
					addrNext   = addr + 8'd1;
					accessNext = 1'b0;
					stateNext  = walkAdvance;
				end
			walkAdvance:
			begin
				stateNext = walkCheck;
				case (addr)
					gapFrom:    addrNext = gapTo;
					alarmCheck: addrNext = (alarmWanted || !irq) ? alarmLow : cmdAddr;
					alarmHigh:
						if (alarmWanted)
							timerConsume = btn.timerReq;  // Stay one more transfer
						else
							addrNext = cmdAddr;
					resetAddr:  addrNext = cmdAddr;       // Alarm block finished
					default:
					begin
					end
				endcase
			end
			walkCheck:
				if (addr == scanEnd)
				begin
					scanDone  = 1'b1;
					addrNext  = scanStart;  // Parked on the start of the next pass
					stateNext = walkIdle;
				end
				else
				begin
					accessNext = 1'b1;
					stateNext  = walkTransfer;
				end
			default: stateNext = walkIdle;
		endcase

		if (accessExpired)
			accessNext = 1'b0;  // Held too long, drop regardless of frw
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			state    <= walkBoot;
			addr     <= resetAddr;
			access   <= 1'b1;  // RTC init transfer starts out of reset
			bootSeen <= 1'b0;
		end
		else
		begin
			state    <= stateNext;
			addr     <= addrNext;
			access   <= accessNext;
			bootSeen <= bootSeenNext;
		end
	end

	// Status back to the sequencer
	assign scan.scanDone   = scanDone;
	assign scan.atStart    = (addr == scanStart);
	assign scan.atCmd      = (addr == cmdAddr);
	assign scan.modPending = (addr == alarmLow) || (addr == alarmHigh);
	assign btn.timerConsume = timerConsume;

endmodule

//--- hdl/btnIf.sv
// Stage interfaces: button press pulses with timer request, and pass request/status links
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Button stage to pointer, sequencer and walker
////////////////////////////////////////////////////////////
interface btnIf;
	import menuCtrlPkg::*;

	btnPulseT press;         // One-cycle press pulses
	logic     timerReq;      // Sticky request from a timerOn edge
	logic     timerConsume;  // Walker served the request

	modport source (output press, output timerReq, input timerConsume);
	modport sink (input press);                                // Pointer and sequencer
	modport timerSink (input timerReq, output timerConsume);   // Walker side
endinterface

////////////////////////////////////////////////////////////
// Sequencer to walker
////////////////////////////////////////////////////////////
interface scanIf;
	logic scanReq;     // Level, holds a pass
	logic scanDone;    // Pulse at end of pass
	logic atStart;     // Walker address is scanStart
	logic atCmd;       // Walker address is cmdAddr
	logic modPending;  // Walker sits on an alarm register

	modport master (output scanReq, input scanDone, input atStart, input atCmd,
		input modPending);
	modport slave (input scanReq, output scanDone, output atStart, output atCmd,
		output modPending);
endinterface

//--- hdl/buttonEdge.sv
// Button stage: samples the panel buttons and timerOn, emits one-cycle rising-edge pulses
`timescale 1ns/1ps

module buttonEdge
(
	input  logic CLK,
	input  logic RST,
	input  logic up,
	input  logic down,
	input  logic left,
	input  logic right,
	input  logic center,
	input  logic timerOn,
	btnIf.source btn
);
	import menuCtrlPkg::*;

	btnPulseT levelNow;   // Raw button levels in struct form
	btnPulseT levelPrev;  // Levels seen on the last edge
	btnPulseT pressReg;   // Registered edge pulses
	logic     timerPrev;
	logic     timerReq;   // Held until the walker takes it

	always_comb
	begin
		levelNow.up     = up;
		levelNow.down   = down;
		levelNow.left   = left;
		levelNow.right  = right;
		levelNow.center = center;
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			levelPrev <= '0;
			pressReg  <= '0;
			timerPrev <= 1'b0;
			timerReq  <= 1'b0;
		end
		else
		begin
			levelPrev <= levelNow;
			pressReg  <= levelNow & ~levelPrev;  // High for one cycle per press
			timerPrev <= timerOn;
			if (timerOn && !timerPrev)
				timerReq <= 1'b1;                 // New press wins over a consume
			else if (btn.timerConsume)
				timerReq <= 1'b0;
		end
	end

	assign btn.press    = pressReg;
	assign btn.timerReq = timerReq;

endmodule

//--- hdl/editPointer.sv
// Edit pointer stage: steps the field pointer on left/right presses and wraps around the hole
`timescale 1ns/1ps

module editPointer
(
	input  logic          CLK,
	input  logic          RST,
	btnIf.sink            btn,
	output rtcMapPkg::ptrT ptr
);
	import rtcMapPkg::*;

	ptrT ptrNext;

	////////////////////////////////////////////////////////////
	// Next pointer
	////////////////////////////////////////////////////////////
	always_comb
	begin
		// Left moves up the map, right moves down
		ptrNext = ptr + ptrT'(btn.press.left) - ptrT'(btn.press.right);

		// A pointer sitting on a limit is moved off it first
		case (ptr)
			ptrGapLow:  ptrNext = ptrGapLowWrap;   // Jump over the hole upward
			ptrCeil:    ptrNext = ptrCeilWrap;     // Past the top, back to first field
			ptrFloor:   ptrNext = ptrFloorWrap;    // Below first field, to the top
			ptrGapHigh: ptrNext = ptrGapHighWrap;  // Jump over the hole downward
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			ptr <= ptrFloor;  // Settles to the top field on the next edge
		else
			ptr <= ptrNext;
	end

endmodule

//--- hdl/menuCtrlPkg.sv
// Menu control types: button press pulses and the sequencer and walker state encodings
package menuCtrlPkg;

	////////////////////////////////////////////////////////////
	// Button press pulses, one bit per panel button
	////////////////////////////////////////////////////////////
	typedef struct packed
	{
		logic up;      // Marks clock contents modified
		logic down;    // Same as up for the flag
		logic left;    // Pointer plus one
		logic right;   // Pointer minus one
		logic center;
	} btnPulseT;

	////////////////////////////////////////////////////////////
	// State encodings
	////////////////////////////////////////////////////////////

	// Pass sequencer
	typedef enum logic [1:0]
	{
		seqInit,   // Waiting for RTC init
		seqScan,   // Pass requested and running
		seqWait    // Pause between passes
	} seqStateT;

	// Address walker
	typedef enum logic [2:0]
	{
		walkBoot,      // RTC init transfers at resetAddr
		walkIdle,      // Waiting for a pass request
		walkTransfer,  // Access out, waiting for frw
		walkAdvance,   // Skip rules on the incremented address
		walkCheck      // End test and next access
	} walkStateT;

endpackage

//--- hdl/rtcMapPkg.sv
// RTC register map: address type, scan and skip addresses, edit pointer field limits
package rtcMapPkg;

	typedef logic [7:0] rtcAddrT;  // One RTC register address
	typedef logic [6:0] ptrT;      // Edit pointer into the editable fields

	////////////////////////////////////////////////////////////
	// Scan walk addresses
	////////////////////////////////////////////////////////////
	localparam rtcAddrT scanStart  = 8'h21;  // First register of every pass
	localparam rtcAddrT gapFrom    = 8'h27;  // Start of the unused hole
	localparam rtcAddrT gapTo      = 8'h41;  // First register after the hole
	localparam rtcAddrT alarmCheck = 8'h44;  // Decide whether alarm regs are visited
	localparam rtcAddrT alarmLow   = 8'h00;
	localparam rtcAddrT alarmHigh  = 8'h01;
	localparam rtcAddrT cmdAddr    = 8'hF0;  // Command register, closes a pass
	localparam rtcAddrT scanEnd    = 8'hF1;  // End marker, never accessed
	localparam rtcAddrT resetAddr  = 8'h02;  // Held during RTC init

	////////////////////////////////////////////////////////////
	// Edit pointer limits and the value each one wraps to
	////////////////////////////////////////////////////////////
	localparam ptrT ptrFloor       = 7'h20;  // Below first field
	localparam ptrT ptrGapLow      = 7'h27;  // Entering the hole going up
	localparam ptrT ptrGapHigh     = 7'h40;  // Entering the hole going down
	localparam ptrT ptrCeil        = 7'h45;  // Above last field
	localparam ptrT ptrFloorWrap   = 7'h43;
	localparam ptrT ptrGapLowWrap  = 7'h41;
	localparam ptrT ptrGapHighWrap = 7'h26;
	localparam ptrT ptrCeilWrap    = 7'h21;

endpackage

//--- hdl/rtcMenu.sv
// RTC front panel menu and scan controller top level
`timescale 1ns/1ps

module rtcMenu
#(
	parameter int waitCycles  = 3,  // Pause between passes
	parameter int accessLimit = 8   // Longest access strobe
)
(
	input  logic               CLK,
	input  logic               RST,
	input  logic               up,
	input  logic               down,
	input  logic               left,
	input  logic               right,
	input  logic               center,
	input  logic               timerOn,
	input  logic               alarmStop,
	input  logic               irq,
	input  logic               frw,
	output logic               access,
	output rtcMapPkg::rtcAddrT addr,
	output rtcMapPkg::ptrT     ptr,
	output logic               modOut
);

	btnIf  btnBus ();   // Press pulses and timer request
	scanIf scanBus ();  // Pass request and walker status

	////////////////////////////////////////////////////////////
	// Stages
	////////////////////////////////////////////////////////////
	buttonEdge uButtons
	(
		.CLK     (CLK),
		.RST     (RST),
		.up      (up),
		.down    (down),
		.left    (left),
		.right   (right),
		.center  (center),
		.timerOn (timerOn),
		.btn     (btnBus.source)
	);

	editPointer uPointer
	(
		.CLK (CLK),
		.RST (RST),
		.btn (btnBus.sink),
		.ptr (ptr)
	);

	scanSequencer #(.waitCycles(waitCycles)) uSequencer
	(
		.CLK    (CLK),
		.RST    (RST),
		.frw    (frw),
		.btn    (btnBus.sink),
		.scan   (scanBus.master),
		.modOut (modOut)
	);

	addrWalker #(.accessLimit(accessLimit)) uWalker
	(
		.CLK       (CLK),
		.RST       (RST),
		.frw       (frw),
		.alarmStop (alarmStop),
		.irq       (irq),
		.btn       (btnBus.timerSink),
		.scan      (scanBus.slave),
		.access    (access),
		.addr      (addr)
	);

endmodule

//--- hdl/scanSequencer.sv
// Pass sequencer: init, scan and wait control of the map walk, plus the modified flag
`timescale 1ns/1ps

module scanSequencer
#(
	parameter int waitCycles = 3
)
(
	input  logic  CLK,
	input  logic  RST,
	input  logic  frw,
	btnIf.sink    btn,
	scanIf.master scan,
	output logic  modOut
);
	import menuCtrlPkg::*;

	localparam int cntW = $clog2(waitCycles + 2);

	seqStateT        state;
	seqStateT        stateNext;
	logic [cntW-1:0] waitCnt;    // Cycles spent in wait
	logic            waitDone;
	logic            editPress;  // Up or down this cycle
	logic            modFlag;    // Contents changed since last full pass
	logic            passArmed;  // Pass start seen while modified
	logic            passCmd;    // Then the command address seen

	////////////////////////////////////////////////////////////
	// Init, scan and wait
	////////////////////////////////////////////////////////////
	assign waitDone = (state == seqWait) && (waitCnt == cntW'(waitCycles));

	always_comb
	begin
		stateNext = state;
		case (state)
			seqInit: if (frw) stateNext = seqScan;             // RTC init finished
			seqScan: if (scan.scanDone) stateNext = seqWait;
			seqWait: if (waitDone) stateNext = seqScan;
			default: stateNext = seqInit;
		endcase
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			state   <= seqInit;
			waitCnt <= '0;
		end
		else
		begin
			state <= stateNext;
			if (state == seqWait && !waitDone)
				waitCnt <= waitCnt + 1'b1;
			else
				waitCnt <= '0;  // Ready for the next pause
		end
	end

	assign scan.scanReq = (state == seqScan);  // Held for the whole pass

	////////////////////////////////////////////////////////////
	// Modified flag
	////////////////////////////////////////////////////////////
	assign editPress = btn.press.up | btn.press.down;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			modFlag   <= 1'b1;  // Contents unknown after reset
			passArmed <= 1'b0;
			passCmd   <= 1'b0;
		end
		else if (editPress)
		begin
			modFlag   <= 1'b1;
			passArmed <= 1'b0;  // A full pass must follow the last edit
			passCmd   <= 1'b0;
		end
		else if (scan.scanDone)
		begin
			if (passCmd)
				modFlag <= 1'b0;  // Written back through the command register
			passArmed <= 1'b0;
			passCmd   <= 1'b0;
		end
		else
		begin
			if (scan.atStart && modFlag)
				passArmed <= 1'b1;
			if (scan.atCmd && passArmed)
				passCmd <= 1'b1;
		end
	end

	// Alarm registers always count as modified
	assign modOut = modFlag | scan.modPending;

endmodule

//--- rtcMenu.f
hdl/rtcMapPkg.sv
hdl/menuCtrlPkg.sv
hdl/btnIf.sv
hdl/buttonEdge.sv
hdl/editPointer.sv
hdl/scanSequencer.sv
hdl/addrWalker.sv
hdl/rtcMenu.sv
tb/rtcMenu_assert.sv
tb/rtcMenuTb.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rtcMenuTb -f rtcMenu.f -o rtcMenuSim \
	&& ./obj_dir/rtcMenuSim > sim.log 2>&1 \
	|| echo "Build or simulation returned an error status"
grep -q "^TESTBENCH PASSED" sim.log && echo "Result: pass" && exit 0 \
	|| { echo "Result: fail, see sim.log"; exit 1; }

//--- tb/rtcMenuTb.sv
// Testbench for the RTC menu controller, driven from a vector file, with an RTC transfer model
`timescale 1ns/1ps

module rtcMenuTb;
	import rtcMapPkg::*;

	localparam int waitCycles  = 3;
	localparam int accessLimit = 8;
	localparam int maxLines    = 32;
	localparam int maxAddrs    = 12;  // Longest pass, both alarm registers included

	logic    CLK;
	logic    RST;
	logic    up;
	logic    down;
	logic    left;
	logic    right;
	logic    center;
	logic    timerOn;
	logic    alarmStop;
	logic    irq;
	logic    frw;
	logic    access;
	rtcAddrT addr;
	ptrT     ptr;
	logic    modOut;

	////////////////////////////////////////////////////////////
	// Vector table and run state
	////////////////////////////////////////////////////////////
	string   vecName  [maxLines];
	string   vecPress [maxLines];  // Button keys in press order
	logic    vecStop  [maxLines];
	logic    vecIrq   [maxLines];
	logic    vecTimer [maxLines];
	ptrT     vecPtr   [maxLines];
	int      vecCount [maxLines];
	rtcAddrT vecAddr  [maxLines][maxAddrs];
	int      lineCount = 0;

	rtcAddrT     seenAddr[$];            // Address at each frw of the running pass
	int          passCount  = 0;         // Passes closed at the command register
	int          bootLeft   = 2;         // RTC init transfers still expected
	logic        modelOn    = 1'b0;
	string       curName    = "boot";
	logic [31:0] lfsrState  = 32'h50fa;
	int          cycleCount = 0;
	int          cycleLimit = 0;

	rtcMenu #(.waitCycles(waitCycles), .accessLimit(accessLimit)) i_dut
	(
		.CLK       (CLK),
		.RST       (RST),
		.up        (up),
		.down      (down),
		.left      (left),
		.right     (right),
		.center    (center),
		.timerOn   (timerOn),
		.alarmStop (alarmStop),
		.irq       (irq),
		.frw       (frw),
		.access    (access),
		.addr      (addr),
		.ptr       (ptr),
		.modOut    (modOut)
	);

	always #50 CLK = ~CLK;  // 100 ns period

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	task automatic tick();
		@(posedge CLK);
		#10;  // Drive and sample point
	endtask

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic checkAddr(input string testName, input rtcAddrT expected, input rtcAddrT actual);
		if (actual !== expected)
			stopWithFailure($sformatf("Mismatch in %s: addr expected %h, actual %h",
				testName, expected, actual));
	endtask

	task automatic checkPtr(input string testName, input ptrT expected, input ptrT actual);
		if (actual !== expected)
			stopWithFailure($sformatf("Mismatch in %s: ptr expected %h, actual %h",
				testName, expected, actual));
	endtask

	task automatic checkFlag(input string testName, input logic expected, input logic actual);
		if (actual !== expected)
			stopWithFailure($sformatf("Mismatch in %s: flag expected %b, actual %b",
				testName, expected, actual));
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic drawDelay(output int delay);
		logic b0;
		logic b1;
		lfsrState = lfsrNext(lfsrState);
		b0        = lfsrState[0];
		lfsrState = lfsrNext(lfsrState);
		b1        = lfsrState[0];
		delay     = 1 + int'({b1, b0});  // One to four cycles
	endtask

	task automatic readVectors();
		int    fd;
		int    rc;
		string line;
		string nameTmp;
		string pressTmp;
		int    stopTmp;
		int    irqTmp;
		int    timerTmp;
		int    ptrTmp;
		int    countTmp;
		int    av [maxAddrs];
		fd = $fopen("tb/rtcMenu_vectors.txt", "r");
		if (fd == 0)
			stopWithFailure("Cannot open the vector file tb/rtcMenu_vectors.txt");
		while (!$feof(fd))
		begin
			line = "";
			rc   = $fgets(line, fd);
			if (rc > 0 && line.len() > 1 && line[0] != "#")  // Skip blanks and comments
			begin
				rc = $sscanf(line, "%s %d %d %d %s %h %d %h %h %h %h %h %h %h %h %h %h %h %h",
					nameTmp, stopTmp, irqTmp, timerTmp, pressTmp, ptrTmp, countTmp,
					av[0], av[1], av[2], av[3], av[4], av[5],
					av[6], av[7], av[8], av[9], av[10], av[11]);
				if (rc != 19 || countTmp < 1 || countTmp > maxAddrs || lineCount == maxLines)
					stopWithFailure($sformatf("Vector line %0d is malformed", lineCount + 1));
				vecName[lineCount]  = nameTmp;
				vecPress[lineCount] = pressTmp;
				vecStop[lineCount]  = stopTmp[0];
				vecIrq[lineCount]   = irqTmp[0];
				vecTimer[lineCount] = timerTmp[0];
				vecPtr[lineCount]   = ptrT'(ptrTmp);
				vecCount[lineCount] = countTmp;
				for (int i = 0; i < maxAddrs; i++)
					vecAddr[lineCount][i] = rtcAddrT'(av[i]);
				lineCount++;
			end
		end
		$fclose(fd);
		if (lineCount == 0)
			stopWithFailure("The vector file holds no test lines");
	endtask

	// One press is one cycle high then one cycle low
	task automatic pressButton(input byte key);
		case (key)
			"U": up      = 1'b1;
			"D": down    = 1'b1;
			"L": left    = 1'b1;
			"R": right   = 1'b1;
			"C": center  = 1'b1;
			"T": timerOn = 1'b1;
			default: return;  // No key
		endcase
		tick();
		up      = 1'b0;
		down    = 1'b0;
		left    = 1'b0;
		right   = 1'b0;
		center  = 1'b0;
		timerOn = 1'b0;
		tick();
	endtask

	// Called on the cycle the model raises frw
	task automatic recordTransfer();
		if (bootLeft > 0)
		begin
			checkAddr("boot", resetAddr, addr);  // Init transfers at the reset address
			bootLeft--;
		end
		else
		begin
			seenAddr.push_back(addr);
			if (addr == alarmLow || addr == alarmHigh)
				checkFlag({curName, " alarm"}, 1'b1, modOut);  // Alarm regs read as modified
			if (seenAddr.size() > maxAddrs)
				stopWithFailure("The pass ran past the longest walk without the command register");
			if (addr == cmdAddr)
				passCount++;
		end
	endtask

	task automatic runStep(input int s);
		logic edited;
		edited    = 1'b0;
		curName   = vecName[s];
		alarmStop = vecStop[s];
		irq       = vecIrq[s];
		for (int i = 0; i < vecPress[s].len(); i++)
		begin
			if (vecPress[s][i] == "U" || vecPress[s][i] == "D")
				edited = 1'b1;
			pressButton(vecPress[s][i]);
		end
		if (vecTimer[s])
			pressButton("T");
		if (edited)
			checkFlag({curName, " edit"}, 1'b1, modOut);
		wait (passCount == s + 1);
		repeat (3) tick();  // Past scanDone and the flag update
		for (int i = 0; i < vecCount[s]; i++)
		begin
			if (i >= int'(seenAddr.size()))
				stopWithFailure($sformatf("Pass of %s ended after %0d transfers", curName, i));
			checkAddr(curName, vecAddr[s][i], seenAddr[i]);
		end
		seenAddr.delete();
		checkPtr(curName, vecPtr[s], ptr);
		checkFlag(curName, 1'b0, modOut);  // Cleared by the complete pass
	endtask

	////////////////////////////////////////////////////////////
	// RTC bus model, one frw pulse per access
	////////////////////////////////////////////////////////////
	initial
	begin : rtcModel
		int delay;
		frw = 1'b0;
		wait (modelOn);
		forever
		begin
			tick();
			if (access)
			begin
				drawDelay(delay);
				repeat (delay - 1) tick();
				recordTransfer();
				frw = 1'b1;
				tick();
				frw = 1'b0;
			end
		end
	end

	// Watchdog
	always @(posedge CLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
			stopWithFailure($sformatf("Timeout, the run did not finish in %0d cycles", cycleLimit));
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		CLK       = 1'b0;
		RST       = 1'b1;
		up        = 1'b0;
		down      = 1'b0;
		left      = 1'b0;
		right     = 1'b0;
		center    = 1'b0;
		timerOn   = 1'b0;
		alarmStop = 1'b0;
		irq       = 1'b1;
		readVectors();
		cycleLimit = (lineCount + 1) * (16 * 5 + waitCycles + 2);  // Extra line covers init
		repeat (5) @(posedge CLK);
		#10;
		RST = 1'b0;
		checkFlag("reset access", 1'b1, access);
		checkAddr("reset", resetAddr, addr);
		checkFlag("reset modOut", 1'b1, modOut);
		modelOn = 1'b1;
		for (int s = 0; s < lineCount; s++)
			runStep(s);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- tb/rtcMenu_assert.sv
// Walker invariant checks: access strobe length, no address inside the map hole, restart after a pass
`timescale 1ns/1ps

module walkerInvariants
#(
	parameter int accessLimit = 8
)
(
	input logic               CLK,
	input logic               RST,
	input logic               access,
	input rtcMapPkg::rtcAddrT addr,
	input logic               scanDone
);
	import rtcMapPkg::*;

	int highCnt;  // Earlier consecutive cycles with access high

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			highCnt <= 0;
		else if (access)
			highCnt <= highCnt + 1;
		else
			highCnt <= 0;
	end

	// At most accessLimit high samples in a row
	accessBounded: assert property (@(posedge CLK) disable iff (RST)
		access |-> (highCnt < accessLimit))
		else $error("access strobe held high past its limit");

	// 0x28 up to 0x40 is never driven, the walk jumps from gapFrom to gapTo
	gapSkipped: assert property (@(posedge CLK) disable iff (RST)
		(addr <= gapFrom) || (addr >= gapTo))
		else $error("walker address %h lies inside the map hole", addr);

	passRestart: assert property (@(posedge CLK) disable iff (RST)
		scanDone |=> (addr == scanStart))  // Parked on the first register
		else $error("address is not the scan start after the end of a pass");

endmodule

bind addrWalker walkerInvariants #(.accessLimit(accessLimit)) uInvariants
(
	.CLK      (CLK),
	.RST      (RST),
	.access   (access),
	.addr     (addr),
	.scanDone (scanDone)
);

//--- tb/rtcMenu_vectors.txt
# name alarmStop irq timerPress keys(U D L R C, - none) ptr(hex) count addr0..addr11(hex)
# addr slots after count are unused and hold ff
init            0 1 0 -     43 10 21 22 23 24 25 26 41 42 43 f0 ff ff
step_left       0 1 0 L     44 10 21 22 23 24 25 26 41 42 43 f0 ff ff
wrap_top        0 1 0 L     21 10 21 22 23 24 25 26 41 42 43 f0 ff ff
wrap_floor_irq  0 0 0 R     43 11 21 22 23 24 25 26 41 42 43 00 f0 ff
alarm_stop_up   1 1 0 U     43 12 21 22 23 24 25 26 41 42 43 00 01 f0
timer_press     0 1 1 -     43 12 21 22 23 24 25 26 41 42 43 00 01 f0
timer_served    0 1 0 LL    21 10 21 22 23 24 25 26 41 42 43 f0 ff ff
walk_fields     0 1 0 LLLLL 26 10 21 22 23 24 25 26 41 42 43 f0 ff ff
gap_up          0 1 0 L     41 10 21 22 23 24 25 26 41 42 43 f0 ff ff
gap_down_irq    0 0 0 R     26 11 21 22 23 24 25 26 41 42 43 00 f0 ff
alarm_down_edit 1 0 0 DRR   24 12 21 22 23 24 25 26 41 42 43 00 01 f0
timer_irq_edit  0 0 1 UL    25 12 21 22 23 24 25 26 41 42 43 00 01 f0
